// File: rtl/harness_cfg.svh
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// ------------------------------------------------------------
// Serial link
// ------------------------------------------------------------

// Clock cycles per serial bit
// Keep even so the mid-bit sample point is exact
`define UART_CLKS_PER_BIT 16

// ------------------------------------------------------------
// Block store
// ------------------------------------------------------------

// Address width, 256 blocks
`define STORE_ADDR_BITS 8

// Cycles from req rising to ack rising
`define STORE_LATENCY 4

`endif

// File: rtl/uartPkg.sv
package uartPkg;

	// ------------------------------------------------------------
	// Serial link types
	// ------------------------------------------------------------

	// One 8N1 payload byte
	typedef logic [7:0] byteT;

	// Bit index within a frame
	// Only data bits 0..7 are counted
	typedef logic [3:0] bitCountT;

	// Receiver FSM
	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxStateE;

	// Transmitter FSM
	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txStateE;

endpackage

// File: rtl/harnessPkg.sv
`include "harness_cfg.svh"

package harnessPkg;

	// ------------------------------------------------------------
	// Command word layout
	// ------------------------------------------------------------

	// Field widths
	localparam int opcodeBits = 8;
	localparam int addrBits = `STORE_ADDR_BITS;
	localparam int dataBits = 32;

	// Opcode, address, data from the top down
	localparam int cmdBits = opcodeBits + addrBits + dataBits;
	localparam int addrLsb = dataBits;
	localparam int opcodeLsb = dataBits + addrBits;

	// Opcode values follow the ORAM harness
	typedef enum logic [opcodeBits-1:0] {
		opWrite = 8'd0,
		opRead = 8'd2
	} opcodeT;

	// Block address and block data
	typedef logic [addrBits-1:0] addrT;
	typedef logic [dataBits-1:0] dataT;

	// Full command, 6 bytes on the wire
	typedef logic [cmdBits-1:0] cmdWordT;

	// ------------------------------------------------------------
	// Harness FSM
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		stIdle,
		stRequest,
		stWaitAck,
		stRelease,
		stRespond
	} harnessStateE;

endpackage

// File: rtl/uartLink.sv
`timescale 1ns/100ps
`include "harness_cfg.svh"

module uartLink (
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic uartRxd,
	output logic uartTxd,
	output uartPkg::byteT rxByte,
	output logic rxValid,
	input  logic rxReady,
	input  uartPkg::byteT txByte,
	input  logic txValid,
	output logic txReady
);

	// Bit-time counter sized to hold a full bit
	localparam int clkBits = $clog2(`UART_CLKS_PER_BIT + 1);
	localparam logic [clkBits-1:0] bitLast = clkBits'(`UART_CLKS_PER_BIT - 1);
	localparam logic [clkBits-1:0] halfLast = clkBits'(`UART_CLKS_PER_BIT / 2 - 1);
	localparam uartPkg::bitCountT lastBit = 4'd7;

	// ------------------------------------------------------------
	// Receiver
	// ------------------------------------------------------------
	uartPkg::rxStateE rxState;
	logic [1:0] rxSync;
	logic rxd;
	logic [clkBits-1:0] rxClkCnt;
	uartPkg::bitCountT rxBitCnt;
	uartPkg::byteT rxShift;
	logic rxSample;
	logic rxDone;

	// Two-flop synchronizer, idles high
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], uartRxd};
		end
	end
	assign rxd = rxSync[1];

	// Mid-bit strobes
	assign rxSample = (rxState == uartPkg::rxData) && (rxClkCnt == bitLast);
	assign rxDone = (rxState == uartPkg::rxStop) && (rxClkCnt == bitLast) && rxd;

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			rxState <= uartPkg::rxIdle;
			rxClkCnt <= '0;
			rxBitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			// New byte wins over a pending one
			if (rxDone) begin
				rxValid <= 1'b1;
			end else if (rxReady) begin
				rxValid <= 1'b0;
			end
			case (rxState)
				uartPkg::rxIdle: begin
					rxClkCnt <= '0;
					if (!rxd) begin
						rxState <= uartPkg::rxStart;
					end
				end
				uartPkg::rxStart: begin
					// Recheck the line at the middle of the start bit
					if (rxClkCnt == halfLast) begin
						rxClkCnt <= '0;
						rxBitCnt <= '0;
						rxState <= rxd ? uartPkg::rxIdle : uartPkg::rxData;
					end else begin
						rxClkCnt <= rxClkCnt + 1'b1;
					end
				end
				uartPkg::rxData: begin
					if (rxClkCnt == bitLast) begin
						rxClkCnt <= '0;
						if (rxBitCnt == lastBit) begin
							rxState <= uartPkg::rxStop;
						end else begin
							rxBitCnt <= rxBitCnt + 1'b1;
						end
					end else begin
						rxClkCnt <= rxClkCnt + 1'b1;
					end
				end
				uartPkg::rxStop: begin
					// Low stop bit just falls back to idle
					if (rxClkCnt == bitLast) begin
						rxClkCnt <= '0;
						rxState <= uartPkg::rxIdle;
					end else begin
						rxClkCnt <= rxClkCnt + 1'b1;
					end
				end
				default: rxState <= uartPkg::rxIdle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk_p) begin
		if (rxSample) begin
			rxShift <= {rxd, rxShift[7:1]};
		end
		if (rxDone) begin
			rxByte <= rxShift;
		end
	end

	// ------------------------------------------------------------
	// Transmitter
	// ------------------------------------------------------------
	uartPkg::txStateE txState;
	logic [clkBits-1:0] txClkCnt;
	uartPkg::bitCountT txBitCnt;
	uartPkg::byteT txShift;
	logic txLoad;
	logic txStep;

	assign txReady = (txState == uartPkg::txIdle);
	assign txLoad = txReady && txValid;
	assign txStep = (txState == uartPkg::txData) && (txClkCnt == bitLast);

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			txState <= uartPkg::txIdle;
			txClkCnt <= '0;
			txBitCnt <= '0;
			uartTxd <= 1'b1;
		end else begin
			case (txState)
				uartPkg::txIdle: begin
					txClkCnt <= '0;
					if (txValid) begin
						// Start bit
						uartTxd <= 1'b0;
						txState <= uartPkg::txStart;
					end
				end
				uartPkg::txStart: begin
					if (txClkCnt == bitLast) begin
						txClkCnt <= '0;
						txBitCnt <= '0;
						uartTxd <= txShift[0];
						txState <= uartPkg::txData;
					end else begin
						txClkCnt <= txClkCnt + 1'b1;
					end
				end
				uartPkg::txData: begin
					if (txClkCnt == bitLast) begin
						txClkCnt <= '0;
						if (txBitCnt == lastBit) begin
							uartTxd <= 1'b1;
							txState <= uartPkg::txStop;
						end else begin
							// Next bit, shift happens below
							uartTxd <= txShift[1];
							txBitCnt <= txBitCnt + 1'b1;
						end
					end else begin
						txClkCnt <= txClkCnt + 1'b1;
					end
				end
				uartPkg::txStop: begin
					if (txClkCnt == bitLast) begin
						txClkCnt <= '0;
						txState <= uartPkg::txIdle;
					end else begin
						txClkCnt <= txClkCnt + 1'b1;
					end
				end
				default: txState <= uartPkg::txIdle;
			endcase
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (txLoad) begin
			txShift <= txByte;
		end else if (txStep) begin
			txShift <= txShift >> 1;
		end
	end

endmodule

// File: rtl/shiftRound.sv
`timescale 1ns/100ps

module shiftRound #(
	parameter int iWidth = 8,
	parameter int oWidth = 48
) (
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic [iWidth-1:0] inData,
	input  logic inValid,
	output logic inReady,
	output logic [oWidth-1:0] outData,
	output logic outValid,
	input  logic outReady
);

	// Buffer is the wider side, which must be a whole multiple
	// of the narrow side
	localparam int bufWidth = (iWidth > oWidth) ? iWidth : oWidth;
	localparam int narrowWidth = (iWidth > oWidth) ? oWidth : iWidth;
	localparam int rounds = bufWidth / narrowWidth;
	localparam int cntBits = $clog2(rounds + 1);
	localparam logic [cntBits-1:0] lastRound = cntBits'(rounds - 1);

	logic [bufWidth-1:0] buffer;
	logic [cntBits-1:0] roundCnt;
	logic inFire;
	logic outFire;

	assign inFire = inValid && inReady;
	assign outFire = outValid && outReady;

	// Busy while a word is held, either side
	assign inReady = !outValid;

	generate
		if (iWidth < oWidth) begin : gGather
			// ------------------------------------------------------------
			// Narrow in, wide out
			// ------------------------------------------------------------
			always_ff @(posedge sys_clk_p or negedge rstN) begin
				if (!rstN) begin
					roundCnt <= '0;
					outValid <= 1'b0;
				end else begin
					if (outFire) begin
						outValid <= 1'b0;
					end
					if (inFire) begin
						// Last part in, word is complete
						if (roundCnt == lastRound) begin
							roundCnt <= '0;
							outValid <= 1'b1;
						end else begin
							roundCnt <= roundCnt + 1'b1;
						end
					end
				end
			end

			// First part ends up on top
			always_ff @(posedge sys_clk_p) begin
				if (inFire) begin
					buffer <= (buffer << iWidth) | bufWidth'(inData);
				end
			end

			assign outData = buffer;
		end else begin : gSplit
			// ------------------------------------------------------------
			// Wide in, narrow out
			// ------------------------------------------------------------
			always_ff @(posedge sys_clk_p or negedge rstN) begin
				if (!rstN) begin
					roundCnt <= '0;
					outValid <= 1'b0;
				end else begin
					if (inFire) begin
						roundCnt <= '0;
						outValid <= 1'b1;
					end else if (outFire) begin
						// Empty again after the last part
						if (roundCnt == lastRound) begin
							roundCnt <= '0;
							outValid <= 1'b0;
						end else begin
							roundCnt <= roundCnt + 1'b1;
						end
					end
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inFire) begin
					buffer <= inData;
				end else if (outFire) begin
					buffer <= buffer << oWidth;
				end
			end

			// Top slice is always the next part
			assign outData = buffer[bufWidth-1 -: oWidth];
		end
	endgenerate

endmodule

// File: rtl/cmdHarness.sv
`timescale 1ns/100ps

module cmdHarness (
	input  logic sys_clk_p,
	input  logic rstN,
	input  harnessPkg::cmdWordT cmdWord,
	input  logic cmdValid,
	output logic cmdReady,
	output logic storeReq,
	output logic storeWrite,
	output harnessPkg::addrT storeAddr,
	output harnessPkg::dataT storeWData,
	input  logic storeAck,
	input  harnessPkg::dataT storeRData,
	output harnessPkg::dataT rspWord,
	output logic rspValid,
	input  logic rspReady
);

	harnessPkg::harnessStateE state;
	harnessPkg::cmdWordT cmdReg;
	harnessPkg::dataT rdataReg;
	harnessPkg::opcodeT inOpcode;
	harnessPkg::opcodeT curOpcode;
	logic knownOp;
	logic cmdFire;

	// Opcode of the incoming word and of the held one
	assign inOpcode = harnessPkg::opcodeT'(
		cmdWord[harnessPkg::opcodeLsb +: harnessPkg::opcodeBits]);
	assign curOpcode = harnessPkg::opcodeT'(
		cmdReg[harnessPkg::opcodeLsb +: harnessPkg::opcodeBits]);
	assign knownOp = (inOpcode == harnessPkg::opWrite) || (inOpcode == harnessPkg::opRead);

	assign cmdReady = (state == harnessPkg::stIdle);
	assign cmdFire = cmdValid && cmdReady;

	// ------------------------------------------------------------
	// Four-phase FSM, one command in flight
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			state <= harnessPkg::stIdle;
		end else begin
			case (state)
				harnessPkg::stIdle: begin
					// Unknown opcode is consumed and dropped here
					if (cmdValid && knownOp) begin
						state <= harnessPkg::stRequest;
					end
				end
				// One cycle for address and data to settle before req
				harnessPkg::stRequest: state <= harnessPkg::stWaitAck;
				harnessPkg::stWaitAck: begin
					if (storeAck) begin
						state <= harnessPkg::stRelease;
					end
				end
				harnessPkg::stRelease: begin
					// Writes finish on ack low
					if (!storeAck) begin
						state <= (curOpcode == harnessPkg::opRead) ?
							harnessPkg::stRespond : harnessPkg::stIdle;
					end
				end
				harnessPkg::stRespond: begin
					if (rspReady) begin
						state <= harnessPkg::stIdle;
					end
				end
				default: state <= harnessPkg::stIdle;
			endcase
		end
	end

	// Command and read data holding registers
	always_ff @(posedge sys_clk_p) begin
		if (cmdFire) begin
			cmdReg <= cmdWord;
		end
		if ((state == harnessPkg::stWaitAck) && storeAck) begin
			rdataReg <= storeRData;
		end
	end

	// Store port
	assign storeReq = (state == harnessPkg::stWaitAck);
	assign storeWrite = (curOpcode == harnessPkg::opWrite);
	assign storeAddr = cmdReg[harnessPkg::addrLsb +: harnessPkg::addrBits];
	assign storeWData = cmdReg[harnessPkg::dataBits-1:0];

	// Read reply
	assign rspWord = rdataReg;
	assign rspValid = (state == harnessPkg::stRespond);

endmodule

// File: rtl/blockStore.sv
`timescale 1ns/100ps
`include "harness_cfg.svh"

module blockStore (
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic storeReq,
	input  logic storeWrite,
	input  harnessPkg::addrT storeAddr,
	input  harnessPkg::dataT storeWData,
	output logic storeAck,
	output harnessPkg::dataT storeRData
);

	localparam int depth = 2 ** harnessPkg::addrBits;
	localparam int cntBits = $clog2(`STORE_LATENCY + 1);
	localparam logic [cntBits-1:0] cntLast = cntBits'(`STORE_LATENCY - 1);

	// Stand-in for the ORAM back end
	harnessPkg::dataT mem [depth];

	logic busy;
	logic [cntBits-1:0] latCnt;
	logic expire;

	// Counter runs out, access happens this edge
	assign expire = busy && (latCnt >= cntLast);

	// ------------------------------------------------------------
	// Latency counter and ack
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			latCnt <= '0;
			storeAck <= 1'b0;
		end else begin
			if (storeReq && !busy && !storeAck) begin
				// Fresh request
				busy <= 1'b1;
				latCnt <= cntBits'(1);
			end else if (expire) begin
				busy <= 1'b0;
				latCnt <= '0;
				storeAck <= 1'b1;
			end else if (busy) begin
				latCnt <= latCnt + 1'b1;
			end
			// Drop ack the cycle after req falls
			if (storeAck && !storeReq) begin
				storeAck <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// Array access
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (expire) begin
			if (storeWrite) begin
				mem[storeAddr] <= storeWData;
			end
			// Read data held while ack is high
			storeRData <= mem[storeAddr];
		end
	end

endmodule

// File: rtl/harnessTop.sv
`timescale 1ns/100ps

module harnessTop (
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic uartRxd,
	output logic uartTxd
);

	// Received bytes
	uartPkg::byteT rxByte;
	logic rxValid;
	logic rxReady;

	// Command words
	harnessPkg::cmdWordT cmdWord;
	logic cmdValid;
	logic cmdReady;

	// Read replies
	harnessPkg::dataT rspWord;
	logic rspValid;
	logic rspReady;

	// Bytes to send
	uartPkg::byteT txByte;
	logic txValid;
	logic txReady;

	// Store port
	logic storeReq;
	logic storeWrite;
	harnessPkg::addrT storeAddr;
	harnessPkg::dataT storeWData;
	logic storeAck;
	harnessPkg::dataT storeRData;

	// ------------------------------------------------------------
	// Serial link
	// ------------------------------------------------------------
	uartLink uartLink_inst (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.rxReady(rxReady),
		.txByte(txByte),
		.txValid(txValid),
		.txReady(txReady)
	);

	// Six bytes into one command
	shiftRound #(
		.iWidth($bits(uartPkg::byteT)),
		.oWidth($bits(harnessPkg::cmdWordT))
	) cmdShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(rxByte),
		.inValid(rxValid),
		.inReady(rxReady),
		.outData(cmdWord),
		.outValid(cmdValid),
		.outReady(cmdReady)
	);

	// ------------------------------------------------------------
	// Command execution
	// ------------------------------------------------------------
	cmdHarness cmdHarness_inst (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.cmdWord(cmdWord),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.storeReq(storeReq),
		.storeWrite(storeWrite),
		.storeAddr(storeAddr),
		.storeWData(storeWData),
		.storeAck(storeAck),
		.storeRData(storeRData),
		.rspWord(rspWord),
		.rspValid(rspValid),
		.rspReady(rspReady)
	);

	blockStore blockStore_inst (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.storeReq(storeReq),
		.storeWrite(storeWrite),
		.storeAddr(storeAddr),
		.storeWData(storeWData),
		.storeAck(storeAck),
		.storeRData(storeRData)
	);

	// Reply word out as four bytes
	shiftRound #(
		.iWidth($bits(harnessPkg::dataT)),
		.oWidth($bits(uartPkg::byteT))
	) rspShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(rspWord),
		.inValid(rspValid),
		.inReady(rspReady),
		.outData(txByte),
		.outValid(txValid),
		.outReady(txReady)
	);

endmodule

// File: verification/uartBfm.svh
`ifndef UART_BFM_SVH
`define UART_BFM_SVH

// ------------------------------------------------------------
// Host side of the 8N1 link
// ------------------------------------------------------------

// One frame on uartRxd driven LSB first on falling edges
// Caller must already sit on a falling edge
task automatic sendByte(input uartPkg::byteT b);
	logic [9:0] frame;
	frame = {1'b1, b, 1'b0};
	for (int i = 0; i < 10; i++) begin
		uartRxd = frame[i];
		repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk_p);
	end
endtask

// Six bytes with the opcode byte first
task automatic sendCmd(input harnessPkg::cmdWordT cmd);
	for (int i = 0; i < 6; i++) begin
		sendByte(cmd[47 - 8 * i -: 8]);
	end
endtask

// One frame from uartTxd sampled mid-bit on falling edges
task automatic recvByte(output uartPkg::byteT b);
	// Hunt for the start bit
	while (uartTxd !== 1'b0) begin
		@(negedge sys_clk_p);
	end
	// Middle of the start bit
	repeat (`UART_CLKS_PER_BIT / 2) @(negedge sys_clk_p);
	for (int i = 0; i < 8; i++) begin
		repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk_p);
		b[i] = uartTxd;
	end
	// Stop bit must be high
	repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk_p);
	checkCount++;
	assert (uartTxd === 1'b1) else begin
		errCount++;
		$display("[ERROR] uartTxd stop bit: expected 0x1, got 0x%0h", uartTxd);
	end
endtask

// Four frames with the most significant byte first
task automatic recvWord(output harnessPkg::dataT w);
	uartPkg::byteT b;
	w = '0;
	for (int k = 0; k < 4; k++) begin
		recvByte(b);
		w = {w[23:0], b};
	end
endtask

`endif

// File: verification/harnessTopTb.sv
`timescale 1ns/100ps
`include "harness_cfg.svh"

module harnessTopTb;

	// Quiet window, one four-byte reply plus two bit times
	localparam int rspCycles = (4 * 10 + 2) * `UART_CLKS_PER_BIT;

	// One stimulus row
	// noWait sends the next row without draining replies
	typedef struct packed {
		logic [7:0] opcode;
		harnessPkg::addrT addr;
		harnessPkg::dataT data;
		logic expectRsp;
		logic noWait;
	} rowT;

	logic sys_clk_p;
	logic rstN;
	logic uartRxd;
	logic uartTxd;

	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	integer seed;

	rowT stimRows[$];
	// Reference copy of the store
	harnessPkg::dataT refMem [2 ** harnessPkg::addrBits];
	// Read data still owed by the DUT, oldest first
	harnessPkg::dataT expectQ[$];

	`include "uartBfm.svh"

	harnessTop harnessTop_inst (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd)
	);

	// 8 ns clock
	initial begin
		sys_clk_p = 1'b0;
		forever #4 sys_clk_p = ~sys_clk_p;
	end

	// ------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------
	task automatic addRow(input logic [7:0] opcode, input harnessPkg::addrT addr,
		input harnessPkg::dataT data, input logic randData, input logic expectRsp,
		input logic noWait);
		rowT r;
		r.opcode = opcode;
		r.addr = addr;
		r.data = randData ? harnessPkg::dataT'($random(seed)) : data;
		r.expectRsp = expectRsp;
		r.noWait = noWait;
		stimRows.push_back(r);
	endtask

	task automatic loadTable();
		//     op     addr   data           rnd   rsp   noWait
		// Eight writes, half with random data
		addRow(8'h00, 8'h00, 32'h0123_4567, 1'b0, 1'b0, 1'b0);
		addRow(8'h00, 8'h01, 32'h0000_0000, 1'b1, 1'b0, 1'b0);
		addRow(8'h00, 8'h5A, 32'hDEAD_BEEF, 1'b0, 1'b0, 1'b0);
		addRow(8'h00, 8'h7F, 32'h0000_0000, 1'b1, 1'b0, 1'b0);
		addRow(8'h00, 8'h80, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0);
		addRow(8'h00, 8'hA5, 32'h0000_0000, 1'b1, 1'b0, 1'b0);
		addRow(8'h00, 8'hFE, 32'h8000_0001, 1'b0, 1'b0, 1'b0);
		addRow(8'h00, 8'hFF, 32'h0000_0000, 1'b1, 1'b0, 1'b0);
		// Read them all back
		addRow(8'h02, 8'h00, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'h01, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'h5A, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'h7F, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'h80, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'hA5, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'hFE, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		addRow(8'h02, 8'hFF, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		// Overwrite, newer data expected
		addRow(8'h00, 8'h5A, 32'hC0DE_0042, 1'b0, 1'b0, 1'b0);
		addRow(8'h02, 8'h5A, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		// Unknown opcode, silent and no store update
		addRow(8'hFF, 8'h01, 32'h0BAD_F00D, 1'b0, 1'b0, 1'b0);
		addRow(8'h02, 8'h01, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
		// Back-to-back reads
		addRow(8'h02, 8'hA5, 32'h0000_0000, 1'b0, 1'b1, 1'b1);
		addRow(8'h02, 8'h00, 32'h0000_0000, 1'b0, 1'b1, 1'b1);
		addRow(8'h02, 8'hFF, 32'h0000_0000, 1'b0, 1'b1, 1'b1);
		addRow(8'h02, 8'h7F, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
	endtask

	// Block until every owed reply has come back
	task automatic waitDrain();
		while (expectQ.size() != 0) begin
			@(negedge sys_clk_p);
		end
	endtask

	task automatic reportAndFinish();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	// ------------------------------------------------------------
	// Reset and table loop
	// ------------------------------------------------------------
	initial begin : stimulus
		rowT row;
		seed = 9485;
		rstN = 1'b0;
		uartRxd = 1'b1;
		loadTable();
		repeat (3) @(negedge sys_clk_p);
		rstN = 1'b1;
		@(negedge sys_clk_p);
		checkCount++;
		assert (uartTxd === 1'b1) else begin
			errCount++;
			$display("[ERROR] uartTxd: expected 0x1, got 0x%0h", uartTxd);
		end
		for (int i = 0; i < stimRows.size(); i++) begin
			row = stimRows[i];
			// Reference model, expectation queued before the frames go out
			if (row.opcode == harnessPkg::opWrite) begin
				refMem[row.addr] = row.data;
			end
			if (row.expectRsp) begin
				expectQ.push_back(refMem[row.addr]);
			end
			sendCmd({row.opcode, row.addr, row.data});
			if (!row.noWait) begin
				waitDrain();
				// Silent rows get a window for stray frames
				if (!row.expectRsp) begin
					repeat (rspCycles) @(negedge sys_clk_p);
				end
			end
		end
		waitDrain();
		repeat (rspCycles) @(negedge sys_clk_p);
		reportAndFinish();
	end

	// ------------------------------------------------------------
	// Reply monitor
	// ------------------------------------------------------------
	initial begin : replyMonitor
		harnessPkg::dataT got;
		harnessPkg::dataT exp;
		wait (rstN === 1'b1);
		forever begin
			recvWord(got);
			checkCount++;
			assert (expectQ.size() != 0) else begin
				errCount++;
				$display("Reply word 0x%08h arrived with no read outstanding", got);
			end
			if (expectQ.size() != 0) begin
				exp = expectQ.pop_front();
				checkCount++;
				assert (got === exp) else begin
					errCount++;
					$display("[ERROR] uartTxd word: expected 0x%08h, got 0x%08h", exp, got);
				end
			end
		end
	end

	// Ten frames per row is the worst case
	initial begin : watchdog
		int limit;
		wait (rstN === 1'b1);
		limit = stimRows.size() * 10 * 10 * `UART_CLKS_PER_BIT + 2000;
		while (cycleCount < limit) begin
			@(posedge sys_clk_p);
			cycleCount++;
		end
		errCount++;
		$display("Timeout: the run passed %0d cycles before the table finished", limit);
		reportAndFinish();
	end

endmodule

// File: flist.f
+incdir+rtl
+incdir+verification
rtl/uartPkg.sv
rtl/harnessPkg.sv
rtl/uartLink.sv
rtl/shiftRound.sv
rtl/cmdHarness.sv
rtl/blockStore.sv
rtl/harnessTop.sv
verification/harnessTopTb.sv

// File: Bender.yml
package:
  name: serial_harness

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uartPkg.sv
      - rtl/harnessPkg.sv
      - rtl/uartLink.sv
      - rtl/shiftRound.sv
      - rtl/cmdHarness.sv
      - rtl/blockStore.sv
      - rtl/harnessTop.sv
  - target: test
    include_dirs:
      - rtl
      - verification
    files:
      - verification/harnessTopTb.sv
